// File: vlog.f
+incdir+sim
hw/glu_pkg.sv
hw/a2bus_if.sv
hw/glu_regs.sv
hw/wave_fetch.sv
hw/audio_out.sv
hw/sound_glu.sv
sim/tb_sound_glu.sv

// File: Makefile
SRCS := vlog.f $(wildcard hw/*.sv sim/*.sv sim/*.svh)

all: run

obj_dir/Vtb_sound_glu: $(SRCS)
	verilator --binary --timing --assert --top-module tb_sound_glu -f vlog.f

run: obj_dir/Vtb_sound_glu
	./obj_dir/Vtb_sound_glu > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Result: FAILED" sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: sim/glu_model.svh
/* Reference model and compare tasks for the sound GLU testbench. Included inside
   tb_sound_glu, which supplies count_error and the noise gate settings */
`ifndef GLU_MODEL_SVH
`define GLU_MODEL_SVH

// Byte on data_o for a register offset
function automatic logic [7:0] exp_read_byte(logic [1:0] off, sound_ctrl_t c,
                                             logic [7:0] d, sound_ptr_u p,
                                             logic [7:0] doc_q);
    logic [7:0] r;
    case (off)
        REG_CONTROL: r = c;
        // Stored byte only in RAM mode
        REG_DATA:    r = c.access_ram ? d : doc_q;
        REG_PTR_LO:  r = p.bytes.lo;
        default:     r = p.bytes.hi;
    endcase
    return r;
endfunction

// Pointer after a data write, 16-bit step with carry
function automatic sound_ptr_u exp_ptr_after_write(sound_ptr_u p, sound_ctrl_t c);
    logic [15:0] w;
    w = {p.bytes.hi, p.bytes.lo};
    if (c.auto_inc) begin
        w = w + 16'd1;
    end
    p.bytes.hi = w[15:8];
    p.bytes.lo = w[7:0];
    return p;
endfunction

// Sound RAM write port, wr only for a data write in RAM mode
function automatic mem_req_t exp_ram_req(sound_ptr_u p, sound_ctrl_t c, logic [7:0] d,
                                         logic data_wr);
    mem_req_t r;
    r.addr = SOUND_MEM_BASE + {7'b0, p.mem.index};
    r.rd   = 1'b0;
    r.wr   = data_wr & c.access_ram;
    case (p.mem.lane)
        2'd0:    r.byte_en = 4'b0001;
        2'd1:    r.byte_en = 4'b0010;
        2'd2:    r.byte_en = 4'b0100;
        default: r.byte_en = 4'b1000;
    endcase
    r.data = {d, d, d, d};
    return r;
endfunction

// Wavetable read, whole word
function automatic mem_req_t exp_wave_req(logic [15:0] wa, logic rd);
    mem_req_t r;
    r.addr    = SOUND_MEM_BASE + {7'b0, wa[15:2]};
    r.rd      = rd;
    r.wr      = 1'b0;
    r.byte_en = 4'b1111;
    r.data    = '0;
    return r;
endfunction

function automatic doc_wr_t exp_doc_wr(sound_ptr_u p, sound_ctrl_t c, logic [7:0] d,
                                       logic data_wr);
    doc_wr_t r;
    r.strobe = data_wr & ~c.access_ram;
    r.addr   = p.bytes.lo;
    r.data   = d;
    return r;
endfunction

// Byte of the returned word picked by the lane
function automatic wave_rsp_t exp_wave_rsp(logic [31:0] q, logic [1:0] lane);
    wave_rsp_t r;
    r.ready = 1'b1;
    case (lane)
        2'd0:    r.data = q[7:0];
        2'd1:    r.data = q[15:8];
        2'd2:    r.data = q[23:16];
        default: r.data = q[31:24];
    endcase
    return r;
endfunction

// Volume 12 and up is full scale, below that 4..2 bits of attenuation
function automatic sample_t exp_sample(sample_t s, logic [3:0] vol);
    int      sh;
    sample_t v;
    sh = (vol < 4'd12) ? 4 - int'(vol[3:2]) : 0;
    v = s >>> sh;
    if (GATE_ENABLE && (int'(v) > -GATE_THRESHOLD) && (int'(v) < GATE_THRESHOLD)) begin
        v = '0;
    end
    return v;
endfunction

task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
    if (got !== exp) begin
        $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        count_error();
    end
endtask

// Write data only matters when a write is expected
task automatic check_mem_req(string name, mem_req_t got, mem_req_t exp);
    logic bad;
    bad = (got.addr !== exp.addr) || (got.rd !== exp.rd) || (got.wr !== exp.wr) ||
          (got.byte_en !== exp.byte_en);
    if (exp.wr && (got.data !== exp.data)) begin
        bad = 1'b1;
    end
    if (bad) begin
        $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        count_error();
    end
endtask

task automatic check_doc_wr(string name, doc_wr_t got, doc_wr_t exp);
    if ((got.strobe !== exp.strobe) ||
        (exp.strobe && ((got.addr !== exp.addr) || (got.data !== exp.data)))) begin
        $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        count_error();
    end
endtask

task automatic check_wave(string name, wave_rsp_t got, wave_rsp_t exp);
    if ((got.ready !== exp.ready) || (exp.ready && (got.data !== exp.data))) begin
        $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        count_error();
    end
endtask

task automatic check_sample(string name, sample_t got, sample_t exp);
    if (got !== exp) begin
        $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        count_error();
    end
endtask

`endif

// File: sim/tb_sound_glu.sv
/* Sound GLU testbench. Acts as bus master, sound RAM responder and mixer source,
   and keeps a shadow copy of the registers for the expected values */
`timescale 1ns/100ps
`default_nettype none

module tb_sound_glu
    import glu_pkg::*;
();

    localparam bit GATE_ENABLE    = 1'b1;
    localparam int GATE_THRESHOLD = 16;

    // Cycle budget per test
    localparam int RESET_CYCLES   = 6;
    localparam int DECODE_CYCLES  = 12;
    localparam int PTR_CYCLES     = 20;
    localparam int RAM_CYCLES     = 16;
    localparam int DOC_CYCLES     = 14;
    localparam int WAVE_CYCLES    = 48;
    localparam int AUDIO_CYCLES   = 80;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + DECODE_CYCLES + PTR_CYCLES +
        RAM_CYCLES + DOC_CYCLES + WAVE_CYCLES + AUDIO_CYCLES);

    a2bus_if bus0 ();

    logic        rst;
    logic [7:0]  doc_rdata;
    logic [15:0] wave_addr;
    logic        wave_rd;
    sample_t     left_mix;
    sample_t     right_mix;
    mem_rsp_t    mem_rsp;
    logic [7:0]  data;
    doc_wr_t     doc_wr;
    wave_rsp_t   wave;
    mem_req_t    ram_req;
    mem_req_t    doc_mem_req;
    sample_t     audio_l;
    sample_t     audio_r;

    // Shadow registers
    sound_ctrl_t m_ctrl;
    logic [7:0]  m_data;
    sound_ptr_u  m_ptr;

    int     err_cnt = 0;
    int     test_err = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     cycle_cnt = 0;
    integer seed = 82;

    sound_glu #(
        .NOISE_GATE_ENABLE    (GATE_ENABLE),
        .NOISE_GATE_THRESHOLD (GATE_THRESHOLD)
    ) dut0 (
        .rst_i         (rst),
        .bus           (bus0),
        .doc_rdata_i   (doc_rdata),
        .wave_addr_i   (wave_addr),
        .wave_rd_i     (wave_rd),
        .left_mix_i    (left_mix),
        .right_mix_i   (right_mix),
        .doc_mem_rsp_i (mem_rsp),
        .data_o        (data),
        .doc_wr_o      (doc_wr),
        .wave_o        (wave),
        .ram_req_o     (ram_req),
        .doc_mem_req_o (doc_mem_req),
        .audio_l_o     (audio_l),
        .audio_r_o     (audio_r)
    );

    always #2 bus0.clk_logic = ~bus0.clk_logic;

    always @(posedge bus0.clk_logic) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic count_error();
        err_cnt++;
        test_err++;
    endtask

    `include "glu_model.svh"

    task automatic bus_idle();
        bus0.phi0           = 1'b0;
        bus0.m2sel_n        = 1'b1;
        bus0.addr           = 16'h0000;
        bus0.data           = 8'h00;
        bus0.rw_n           = 1'b1;
        bus0.data_in_strobe = 1'b0;
    endtask

    // One write cycle, strobes checked mid-cycle, shadow updated for the edge
    task automatic bus_write_cycle(logic [15:0] a, logic [7:0] d, logic phi0_v,
                                   logic m2sel_v);
        logic     sel;
        logic     data_wr;
        mem_req_t exp_req;
        doc_wr_t  exp_doc;
        sel     = phi0_v && !m2sel_v && (a[15:2] == GLU_BASE_ADDR[15:2]);
        data_wr = sel && (a[1:0] == REG_DATA);
        exp_req = exp_ram_req(m_ptr, m_ctrl, d, data_wr);
        exp_doc = exp_doc_wr(m_ptr, m_ctrl, d, data_wr);
        bus0.phi0           = phi0_v;
        bus0.m2sel_n        = m2sel_v;
        bus0.addr           = a;
        bus0.data           = d;
        bus0.rw_n           = 1'b0;
        bus0.data_in_strobe = 1'b1;
        #2;
        check_mem_req("ram_req_o", ram_req, exp_req);
        check_doc_wr("doc_wr_o", doc_wr, exp_doc);
        if (sel) begin
            case (a[1:0])
                REG_CONTROL: m_ctrl = sound_ctrl_t'(d);
                REG_DATA: begin
                    m_data = d;
                    m_ptr  = exp_ptr_after_write(m_ptr, m_ctrl);
                end
                REG_PTR_LO: m_ptr.bytes.lo = d;
                default:    m_ptr.bytes.hi = d;
            endcase
        end
        @(posedge bus0.clk_logic);
        #1;
        bus_idle();
    endtask

    task automatic bus_write(logic [15:0] a, logic [7:0] d);
        bus_write_cycle(a, d, 1'b1, 1'b0);
    endtask

    // Read cycle, data_o sampled late in the cycle
    task automatic read_check(logic [15:0] a);
        logic [7:0] got;
        bus0.phi0    = 1'b1;
        bus0.m2sel_n = 1'b0;
        bus0.addr    = a;
        bus0.rw_n    = 1'b1;
        #2;
        got = data;
        check_byte($sformatf("data_o[%h]", a), got,
                   exp_read_byte(a[1:0], m_ctrl, m_data, m_ptr, doc_rdata));
        @(posedge bus0.clk_logic);
        #1;
        bus_idle();
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (test_err == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, test_err);
        end
        test_err = 0;
    endtask

    initial begin
        int          i;
        int          k;
        int          lat;
        logic [15:0] wa;
        logic [31:0] q;
        sample_t     l;
        sample_t     r;
        wave_rsp_t   exp_w;
        bus0.clk_logic = 1'b0;
        bus_idle();
        rst       = 1'b1;
        doc_rdata = 8'h00;
        wave_addr = 16'h0000;
        wave_rd   = 1'b0;
        left_mix  = '0;
        right_mix = '0;
        mem_rsp   = '0;
        m_ctrl    = sound_ctrl_t'(8'h0F);
        m_data    = 8'h00;
        m_ptr     = '0;
        repeat (5) @(posedge bus0.clk_logic);
        #1;
        rst = 1'b0;

        // Reset values, then writes outside the window
        for (i = 0; i < 4; i++) read_check(16'hC03C + 16'(i));
        bus_write_cycle(16'hC03E, 8'hA5, 1'b0, 1'b0);
        bus_write_cycle(16'hC03C, 8'h60, 1'b1, 1'b1);
        bus_write_cycle(16'hC03B, 8'h77, 1'b1, 1'b0);
        for (i = 0; i < 4; i++) read_check(16'hC03C + 16'(i));
        finish_test("reset and decode");

        // Carry from 0x00FF into the high byte
        bus_write(16'hC03E, 8'hFE);
        bus_write(16'hC03F, 8'h00);
        read_check(16'hC03E);
        read_check(16'hC03F);
        bus_write(16'hC03C, 8'h2F);
        for (i = 0; i < 3; i++) begin
            bus_write(16'hC03D, 8'($random(seed)));
            read_check(16'hC03E);
            read_check(16'hC03F);
        end
        bus_write(16'hC03C, 8'h0F);
        bus_write(16'hC03D, 8'h5A);
        read_check(16'hC03E);
        read_check(16'hC03F);
        finish_test("pointer");

        // RAM mode with auto-increment walks all lanes
        bus_write(16'hC03C, 8'h6F);
        bus_write(16'hC03E, 8'($random(seed)));
        bus_write(16'hC03F, 8'($random(seed)));
        for (i = 0; i < 6; i++) begin
            bus_write(16'hC03D, 8'($random(seed)));
            read_check(16'hC03D);
        end
        finish_test("sound ram write");

        bus_write(16'hC03C, 8'h2F);
        for (i = 0; i < 4; i++) begin
            bus_write(16'hC03E, 8'($random(seed)));
            bus_write(16'hC03D, 8'($random(seed)));
            doc_rdata = 8'($random(seed));
            read_check(16'hC03D);
        end
        finish_test("sound chip access");

        // Memory answers after a random latency
        for (i = 0; i < 8; i++) begin
            wa  = 16'($random(seed));
            q   = $random(seed);
            lat = $unsigned($random(seed)) % 4;
            wave_addr = wa;
            wave_rd   = 1'b1;
            #2;
            check_mem_req("doc_mem_req_o", doc_mem_req, exp_wave_req(wa, 1'b1));
            @(posedge bus0.clk_logic);
            #1;
            wave_rd = 1'b0;
            // Address moves on, only the captured lane may pick the byte
            wave_addr = ~wa;
            exp_w   = '0;
            #1;
            check_mem_req("doc_mem_req_o", doc_mem_req, exp_wave_req(~wa, 1'b0));
            repeat (lat) begin
                @(posedge bus0.clk_logic);
                #1;
                check_wave("wave_o", wave, exp_w);
            end
            mem_rsp.ready = 1'b1;
            mem_rsp.q     = q;
            @(posedge bus0.clk_logic);
            #1;
            mem_rsp.ready = 1'b0;
            check_wave("wave_o", wave, exp_wave_rsp(q, wa[1:0]));
            @(posedge bus0.clk_logic);
            #1;
            check_wave("wave_o", wave, exp_w);
        end
        finish_test("wave fetch");

        // Odd samples are small so the gate gets exercised
        for (i = 0; i < 16; i++) begin
            bus_write(16'hC03C, {4'h0, 4'(i)});
            for (k = 0; k < 4; k++) begin
                l = k[0] ? sample_t'($random(seed) % 300) : sample_t'($random(seed));
                r = k[0] ? sample_t'($random(seed) % 300) : sample_t'($random(seed));
                left_mix  = l;
                right_mix = r;
                @(posedge bus0.clk_logic);
                #1;
                // Mix changes after the edge, outputs must hold the registered value
                left_mix  = ~l;
                right_mix = ~r;
                #1;
                check_sample("audio_l_o", audio_l, exp_sample(l, m_ctrl.volume));
                check_sample("audio_r_o", audio_r, exp_sample(r, m_ctrl.volume));
            end
        end
        finish_test("audio output");

        @(posedge bus0.clk_logic);
        $display("Tests: %0d run, %0d failed, %0d check errors", tests_run, tests_failed,
                 err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/sound_glu.sv
/* Sound GLU top. The sound chip sits outside, its register writes, wave reads and
   mix outputs arrive here as ports */
`timescale 1ns/100ps
`default_nettype none

module sound_glu
    import glu_pkg::*;
#(
    parameter bit NOISE_GATE_ENABLE    = 1'b0,
    parameter int NOISE_GATE_THRESHOLD = 16
) (
    input  logic        rst_i,
    a2bus_if.slave      bus,
    input  logic [7:0]  doc_rdata_i,
    input  logic [15:0] wave_addr_i,
    input  logic        wave_rd_i,
    input  sample_t     left_mix_i,
    input  sample_t     right_mix_i,
    input  mem_rsp_t    doc_mem_rsp_i,
    output logic [7:0]  data_o,
    output doc_wr_t     doc_wr_o,
    output wave_rsp_t   wave_o,
    output mem_req_t    ram_req_o,
    output mem_req_t    doc_mem_req_o,
    output sample_t     audio_l_o,
    output sample_t     audio_r_o
);

    // Control register, only volume is used past the register block
    sound_ctrl_t ctrl_w;

    glu_regs regs0 (
        .rst_i       (rst_i),
        .bus         (bus),
        .doc_rdata_i (doc_rdata_i),
        .data_o      (data_o),
        .ctrl_o      (ctrl_w),
        .ram_req_o   (ram_req_o),
        .doc_wr_o    (doc_wr_o)
    );

    // Sound chip wavetable port to sound RAM
    wave_fetch fetch0 (
        .rst_i       (rst_i),
        .clk_i       (bus.clk_logic),
        .wave_addr_i (wave_addr_i),
        .wave_rd_i   (wave_rd_i),
        .mem_rsp_i   (doc_mem_rsp_i),
        .mem_req_o   (doc_mem_req_o),
        .wave_o      (wave_o)
    );

    audio_out #(
        .NOISE_GATE_ENABLE    (NOISE_GATE_ENABLE),
        .NOISE_GATE_THRESHOLD (NOISE_GATE_THRESHOLD)
    ) audio0 (
        .rst_i    (rst_i),
        .clk_i    (bus.clk_logic),
        .volume_i (ctrl_w.volume),
        .left_i   (left_mix_i),
        .right_i  (right_mix_i),
        .left_o   (audio_l_o),
        .right_o  (audio_r_o)
    );

endmodule

`default_nettype wire

// File: hw/audio_out.sv
/* Master volume and noise gate. Volume has four coarse steps only, and the gate
   threshold must lie in 0..128 */
`timescale 1ns/100ps
`default_nettype none

module audio_out
    import glu_pkg::*;
#(
    parameter bit NOISE_GATE_ENABLE    = 1'b0,
    parameter int NOISE_GATE_THRESHOLD = 16
) (
    input  logic       rst_i,
    input  logic       clk_i,
    input  logic [3:0] volume_i,
    input  sample_t    left_i,
    input  sample_t    right_i,
    output sample_t    left_o,
    output sample_t    right_o
);

    localparam sample_t GATE_THR = sample_t'(NOISE_GATE_THRESHOLD);

    logic [2:0] shift_w;
    sample_t    left_r;
    sample_t    right_r;

    // Volume 0..11 gives shift 4..2, 12..15 gives no shift
    assign shift_w = (volume_i < 4'd12) ? 3'd4 - {1'b0, volume_i[3:2]} : 3'd0;

    // Arithmetic shift keeps the sign, gate squashes low-level hiss
    function automatic sample_t scale(sample_t s, logic [2:0] sh);
        sample_t v;
        v = s >>> sh;
        if (NOISE_GATE_ENABLE && (v < GATE_THR) && (v > -GATE_THR)) begin
            v = '0;
        end
        return v;
    endfunction

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            left_r  <= '0;
            right_r <= '0;
        end else begin
            left_r  <= scale(left_i, shift_w);
            right_r <= scale(right_i, shift_w);
        end
    end

    assign left_o  = left_r;
    assign right_o = right_r;

    // Nothing nonzero survives inside the gate window
    a_gate: assert property (@(posedge clk_i) disable iff (rst_i)
        NOISE_GATE_ENABLE |->
            !((left_o != '0) && (left_o < GATE_THR) && (left_o > -GATE_THR)) &&
            !((right_o != '0) && (right_o < GATE_THR) && (right_o > -GATE_THR)));

endmodule

`default_nettype wire

// File: hw/wave_fetch.sv
/* Wavetable fetch. Assumes one read in flight at a time, the sound chip waits for
   ready before issuing the next */
`timescale 1ns/100ps
`default_nettype none

module wave_fetch
    import glu_pkg::*;
(
    input  logic        rst_i,
    input  logic        clk_i,
    input  logic [15:0] wave_addr_i,
    input  logic        wave_rd_i,
    input  mem_rsp_t    mem_rsp_i,
    output mem_req_t    mem_req_o,
    output wave_rsp_t   wave_o
);

    logic [1:0] lane_r;
    logic [7:0] data_r;
    logic       ready_r;

    // Full word read, byte picked on return
    always_comb begin
        mem_req_o.addr    = SOUND_MEM_BASE + MEM_ADDR_W'(wave_addr_i[15:2]);
        mem_req_o.rd      = wave_rd_i;
        mem_req_o.wr      = 1'b0;
        mem_req_o.byte_en = 4'b1111;
        mem_req_o.data    = '0;
    end

    // Lane of the outstanding read
    always_ff @(posedge clk_i) begin
        if (wave_rd_i) begin
            lane_r <= wave_addr_i[1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_rsp_i.ready) begin
            data_r <= mem_rsp_i.q[8*lane_r +: 8];
        end
    end

    // One-cycle ready pulse per memory response
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ready_r <= 1'b0;
        end else begin
            ready_r <= mem_rsp_i.ready;
        end
    end

    assign wave_o.ready = ready_r;
    assign wave_o.data  = data_r;

    a_ready_follows_mem: assert property (@(posedge clk_i) disable iff (rst_i)
        wave_o.ready |-> $past(mem_rsp_i.ready));

endmodule

`default_nettype wire

// File: hw/glu_regs.sv
/* GLU bus registers. RAM writes are posted with no back-pressure, and the read
   mux follows the bus address combinationally */
`timescale 1ns/100ps
`default_nettype none

module glu_regs
    import glu_pkg::*;
(
    input  logic        rst_i,
    a2bus_if.slave      bus,
    input  logic [7:0]  doc_rdata_i,
    output logic [7:0]  data_o,
    output sound_ctrl_t ctrl_o,
    output mem_req_t    ram_req_o,
    output doc_wr_t     doc_wr_o
);

    sound_ctrl_t ctrl_r;
    logic [7:0]  data_r;
    sound_ptr_u  ptr_r;

    logic sel_w;
    logic wr_w;
    logic data_wr_w;

    // Register window hit during phi0 with the slot selected
    assign sel_w = bus.phi0 & ~bus.m2sel_n & (bus.addr[15:2] == GLU_BASE_ADDR[15:2]);
    assign wr_w = sel_w & ~bus.rw_n & bus.data_in_strobe;
    // Data register write, goes to RAM or the sound chip
    assign data_wr_w = wr_w & (bus.addr[1:0] == REG_DATA);

    always_ff @(posedge bus.clk_logic) begin
        if (rst_i) begin
            ctrl_r <= sound_ctrl_t'(CONTROL_RESET);
            data_r <= 8'h00;
            ptr_r  <= '0;
        end else if (wr_w) begin
            case (bus.addr[1:0])
                REG_CONTROL: ctrl_r <= sound_ctrl_t'(bus.data);
                REG_DATA: begin
                    data_r <= bus.data;
                    // Whole 16-bit step so lo carries into hi
                    if (ctrl_r.auto_inc) begin
                        ptr_r <= ptr_r + 16'd1;
                    end
                end
                REG_PTR_LO: ptr_r.bytes.lo <= bus.data;
                REG_PTR_HI: ptr_r.bytes.hi <= bus.data;
                default: ;
            endcase
        end
    end

    // Bus read data
    always_comb begin
        case (bus.addr[1:0])
            REG_CONTROL: data_o = ctrl_r;
            // Stored byte in RAM mode, chip read data in DOC mode
            REG_DATA:    data_o = ctrl_r.access_ram ? data_r : doc_rdata_i;
            REG_PTR_LO:  data_o = ptr_r.bytes.lo;
            default:     data_o = ptr_r.bytes.hi;
        endcase
    end

    assign ctrl_o = ctrl_r;

    // Sound RAM write, byte lane from the pointer
    always_comb begin
        ram_req_o.addr    = SOUND_MEM_BASE + MEM_ADDR_W'(ptr_r.mem.index);
        ram_req_o.rd      = 1'b0;
        ram_req_o.wr      = data_wr_w & ctrl_r.access_ram;
        ram_req_o.byte_en = 4'b0001 << ptr_r.mem.lane;
        // Same byte on every lane, byte_en picks the one written
        ram_req_o.data    = {4{bus.data}};
    end

    // Sound chip register write, register number is pointer lo
    always_comb begin
        doc_wr_o.strobe = data_wr_w & ~ctrl_r.access_ram;
        doc_wr_o.addr   = ptr_r.bytes.lo;
        doc_wr_o.data   = bus.data;
    end

    // A data write reaches exactly one target
    a_one_target: assert property (@(posedge bus.clk_logic) disable iff (rst_i)
        !(ram_req_o.wr && doc_wr_o.strobe));

    a_lane_onehot: assert property (@(posedge bus.clk_logic) disable iff (rst_i)
        ram_req_o.wr |-> $onehot(ram_req_o.byte_en));

endmodule

`default_nettype wire

// File: hw/a2bus_if.sv
/* Apple II bus as seen by the GLU. All signals are inputs to the design and are
   sampled on clk_logic */
`timescale 1ns/100ps
`default_nettype none

interface a2bus_if;

    // Fast logic clock, all GLU state runs on it
    logic        clk_logic;
    // Bus phase, register access only while high
    logic        phi0;
    // Slot I/O select, active low
    logic        m2sel_n;
    logic [15:0] addr;
    logic [7:0]  data;
    // High for read cycles
    logic        rw_n;
    // Single-cycle write data valid strobe
    logic        data_in_strobe;

    modport slave (
        input clk_logic,
        input phi0,
        input m2sel_n,
        input addr,
        input data,
        input rw_n,
        input data_in_strobe
    );

endinterface

`default_nettype wire

// File: hw/glu_pkg.sv
/* Sound GLU shared definitions. Sound RAM is assumed to start at word 0x10000 of a
   32-bit memory, and the pointer only reaches its lower 64K bytes */
`default_nettype none

package glu_pkg;

    // Register window C03C..C03F, selected by the upper fourteen bits
    localparam logic [15:0] GLU_BASE_ADDR = 16'hC03C;

    localparam logic [1:0] REG_CONTROL = 2'd0;
    localparam logic [1:0] REG_DATA    = 2'd1;
    localparam logic [1:0] REG_PTR_LO  = 2'd2;
    localparam logic [1:0] REG_PTR_HI  = 2'd3;

    // Full volume, DOC access, no auto-increment
    localparam logic [7:0] CONTROL_RESET = 8'h0F;

    // Sound control register layout
    typedef struct packed {
        logic       unused_7;
        logic       access_ram;
        logic       auto_inc;
        logic       unused_4;
        logic [3:0] volume;
    } sound_ctrl_t;

    // Sound pointer, seen as bus bytes or as a memory word index plus lane
    typedef union packed {
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
        struct packed {
            logic [13:0] index;
            logic [1:0]  lane;
        } mem;
    } sound_ptr_u;

    localparam int MEM_ADDR_W = 21;

    // Word address of the first sound RAM word
    localparam logic [MEM_ADDR_W-1:0] SOUND_MEM_BASE = 21'h10000;

    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        logic                  rd;
        logic                  wr;
        logic [3:0]            byte_en;
        logic [31:0]           data;
    } mem_req_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] q;
    } mem_rsp_t;

    // Register write towards the sound chip
    typedef struct packed {
        logic       strobe;
        logic [7:0] addr;
        logic [7:0] data;
    } doc_wr_t;

    // Wavetable byte back to the sound chip
    typedef struct packed {
        logic       ready;
        logic [7:0] data;
    } wave_rsp_t;

    typedef logic signed [15:0] sample_t;

endpackage

`default_nettype wire
